/* design/exc_pkg.sv */
package exc_pkg;

	// Widths fixed by the instruction set.
	localparam int WORD_W     = 32; // Data and address words.
	localparam int KIND_W     = 10; // Instruction kind from decode.
	localparam int DP_W       = 5;  // Upper field of a kind.
	localparam int SUB_W      = 5;  // Lower field of a kind.
	localparam int EXC_W      = 5;  // Cause.ExcCode width.
	localparam int NPC_W      = 4;  // Next-PC mode select.
	localparam int CP0_ADDR_W = 5;  // CP0 register number.
	localparam int HW_INT_W   = 6;  // External interrupt lines.

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [KIND_W-1:0]     kind_t;     // {data-path type, subtype}.
	typedef logic [DP_W-1:0]       dptype_t;
	typedef logic [EXC_W-1:0]      exc_code_t;
	typedef logic [NPC_W-1:0]      npc_mode_t;
	typedef logic [CP0_ADDR_W-1:0] cp0_addr_t;
	typedef logic [HW_INT_W-1:0]   hw_int_t;

	// Data-path types, taken from the upper half of a kind.
	localparam dptype_t DP_NONE    = 5'd0;  // Bubble or nop.
	localparam dptype_t DP_CAL_M   = 5'd1;  // Multiply or divide that writes HI/LO.
	localparam dptype_t DP_STORE_M = 5'd2;  // Memory store, or mthi/mtlo.
	localparam dptype_t DP_LOAD    = 5'd3;  // Memory load.
	localparam dptype_t DP_JUMP_C0 = 5'd4;  // Return through EPC.
	localparam dptype_t DP_MTC0    = 5'd5;  // Move to coprocessor 0.

	// Subtypes. For loads and stores they give the access width.
	localparam logic [SUB_W-1:0] SUB_WORD = 5'd0;
	localparam logic [SUB_W-1:0] SUB_HALF = 5'd1;
	localparam logic [SUB_W-1:0] SUB_BYTE = 5'd2;
	localparam logic [SUB_W-1:0] SUB_ERET = 5'd1; // Only meaningful under DP_JUMP_C0.

	// Cause.ExcCode values.
	localparam exc_code_t EXC_NONE = 5'd0;  // No fault found; shares its value with EXC_INT.
	localparam exc_code_t EXC_INT  = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;  // Address error on load.
	localparam exc_code_t EXC_ADES = 5'd5;  // Address error on store.
	localparam exc_code_t EXC_RI   = 5'd10; // Reserved instruction.
	localparam exc_code_t EXC_OV   = 5'd12; // Arithmetic overflow.

	// Fetch mode that loads the interrupt vector into the PC.
	localparam npc_mode_t NPC_ISR = 4'd4;

	// Coprocessor 0 register numbers.
	localparam cp0_addr_t CP0_SR    = 5'd12;
	localparam cp0_addr_t CP0_CAUSE = 5'd13;
	localparam cp0_addr_t CP0_EPC   = 5'd14;
	localparam cp0_addr_t CP0_PRID  = 5'd15;

	localparam word_t PRID_VALUE = 32'h0000_0e1f; // Read-only identification word.

	// Field positions inside Status and Cause.
	localparam int SR_IE_BIT     = 0;
	localparam int SR_EXL_BIT    = 1;
	localparam int SR_IM_LSB     = 10; // IM[7:2] sit in bits 15:10.
	localparam int CAUSE_EXC_LSB = 2;
	localparam int CAUSE_IP_LSB  = 10;
	localparam int CAUSE_BD_BIT  = 31;

endpackage

/* design/exc_if.sv */
`timescale 1ns/1ps

// Trap decision and Status fields shared by the arbiter, CP0 block and handler.
interface exc_if;
	import exc_pkg::*;

	logic      take;      // A trap is taken this cycle.
	exc_code_t code;      // Code that goes into Cause.ExcCode.
	logic      bd;        // The victim sits in a branch-delay slot.
	word_t     victim_pc; // Address that goes into EPC.
	logic      eret;      // Eret retires without a trap.
	logic      ie;        // Status.IE.
	logic      exl;       // Status.EXL.
	hw_int_t   im;        // Status.IM for the hardware lines.

	// The arbiter needs the Status fields to qualify interrupts.
	modport arbiter (
		output take, code, bd, victim_pc, eret,
		input  ie, exl, im
	);

	// The register block owns Status and records the trap.
	modport cp0 (
		input  take, code, bd, victim_pc, eret,
		output ie, exl, im
	);

	modport handler (
		input take
	);

endinterface

/* design/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs (
	input  logic              clk,
	input  logic              rst_n,
	exc_if.cp0                ctl,
	input  exc_pkg::hw_int_t  hw_int, // Live interrupt lines for Cause.IP.
	input  logic              we,     // mtc0 strobe, already gated by the handler.
	input  exc_pkg::cp0_addr_t addr,
	input  exc_pkg::word_t    wdata,
	output exc_pkg::word_t    rdata,
	output exc_pkg::word_t    epc     // Return target for the fetch stage.
);
	import exc_pkg::*;

	// Status fields.
	logic      sr_ie;
	logic      sr_exl;
	hw_int_t   sr_im;

	// Cause fields. IP is not stored since it mirrors the pins.
	logic      cause_bd;
	exc_code_t cause_exc;

	word_t     epc_q;

	// Assembled views for mfc0.
	word_t     sr_word;
	word_t     cause_word;

	// Register update. A trap beats eret and eret beats mtc0.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sr_ie     <= 1'b0; // Interrupts stay off until software enables them.
			sr_exl    <= 1'b0;
			sr_im     <= '0;
			cause_bd  <= 1'b0;
			cause_exc <= EXC_NONE;
			epc_q     <= '0;
		end else if (ctl.take) begin
			// EPC and BD keep the first victim while a handler is already running.
			if (!sr_exl) begin
				epc_q    <= ctl.victim_pc;
				cause_bd <= ctl.bd;
			end
			cause_exc <= ctl.code; // The code always reflects the latest trap.
			sr_exl    <= 1'b1;
		end else if (ctl.eret) begin
			sr_exl <= 1'b0; // Leave exception level on return.
		end else if (we) begin
			case (addr)
				CP0_SR: begin
					sr_ie  <= wdata[SR_IE_BIT];
					sr_exl <= wdata[SR_EXL_BIT];
					sr_im  <= wdata[SR_IM_LSB +: HW_INT_W];
				end
				CP0_EPC: begin
					epc_q <= wdata;
				end
				default: begin
					// Cause and PRId are not writable here.
				end
			endcase
		end
	end

	// Status word with only the implemented bits set.
	always_comb begin
		sr_word                           = '0;
		sr_word[SR_IE_BIT]                = sr_ie;
		sr_word[SR_EXL_BIT]               = sr_exl;
		sr_word[SR_IM_LSB +: HW_INT_W]    = sr_im;
	end

	// Cause word. IP shows the pins in the same cycle.
	always_comb begin
		cause_word                        = '0;
		cause_word[CAUSE_EXC_LSB +: EXC_W] = cause_exc;
		cause_word[CAUSE_IP_LSB +: HW_INT_W] = hw_int;
		cause_word[CAUSE_BD_BIT]          = cause_bd;
	end

	// mfc0 read port is purely combinational.
	always_comb begin
		case (addr)
			CP0_SR:    rdata = sr_word;
			CP0_CAUSE: rdata = cause_word;
			CP0_EPC:   rdata = epc_q;
			CP0_PRID:  rdata = PRID_VALUE;
			default:   rdata = '0; // Unimplemented registers read as zero.
		endcase
	end

	assign epc     = epc_q;

	// Status fields go back to the arbiter through the interface.
	assign ctl.ie  = sr_ie;
	assign ctl.exl = sr_exl;
	assign ctl.im  = sr_im;

endmodule

/* design/exc_arbiter.sv */
`timescale 1ns/1ps

module exc_arbiter (
	input  exc_pkg::kind_t     mkind,  // Kind of the instruction in the memory stage.
	input  exc_pkg::exc_code_t m_exc,  // Code carried down from earlier stages.
	input  exc_pkg::word_t     m_addr, // Effective data address.
	input  exc_pkg::word_t     m_pc,
	input  logic               m_bd,
	input  exc_pkg::hw_int_t   hw_int,
	exc_if.arbiter             ctl
);
	import exc_pkg::*;

	dptype_t          m_dp;
	logic [SUB_W-1:0] m_sub;
	logic             m_active;    // A real instruction occupies the memory stage.
	logic             int_pending;
	logic             misaligned;
	exc_code_t        fault_code;
	exc_code_t        exc_final;
	logic             take;

	assign m_dp  = mkind[KIND_W-1 -: DP_W];
	assign m_sub = mkind[SUB_W-1:0];

	// A bubble can never be the victim of a trap.
	assign m_active = (m_dp != DP_NONE);

	// Unmasked line with interrupts on and no handler running.
	assign int_pending = (|(hw_int & ctl.im)) && ctl.ie && !ctl.exl;

	// Alignment check by access width.
	always_comb begin
		case (m_sub)
			SUB_WORD: misaligned = (m_addr[1:0] != 2'b00);
			SUB_HALF: misaligned = m_addr[0];
			SUB_BYTE: misaligned = 1'b0; // Any byte address is fine.
			default:  misaligned = 1'b0;
		endcase
	end

	// Only loads and stores can raise an address fault.
	always_comb begin
		fault_code = EXC_NONE;
		if (misaligned) begin
			if (m_dp == DP_LOAD) begin
				fault_code = EXC_ADEL;
			end else if (m_dp == DP_STORE_M) begin
				fault_code = EXC_ADES;
			end
		end
	end

	// An earlier stage's code is older, so it wins over a memory fault.
	assign exc_final = (m_exc != EXC_NONE) ? m_exc : fault_code;

	assign take = m_active && (int_pending || (exc_final != EXC_NONE));

	assign ctl.take = take;
	assign ctl.code = int_pending ? EXC_INT : exc_final; // Interrupt beats exception.
	assign ctl.bd   = m_bd;

	// In a delay slot the branch itself has to run again.
	assign ctl.victim_pc = m_bd ? (m_pc - 32'd4) : m_pc;

	// Eret only retires when nothing traps it.
	assign ctl.eret = (m_dp == DP_JUMP_C0) && (m_sub == SUB_ERET) && !take;

endmodule

/* design/exc_handler.sv */
`timescale 1ns/1ps

module exc_handler (
	input  logic                rst_n,
	input  exc_pkg::kind_t      dkind,
	input  exc_pkg::kind_t      ekind,
	input  exc_pkg::kind_t      mkind,
	input  logic                stall,
	exc_if.handler              ctl,

	// Pipeline register flushes.
	output logic                cw_d_pff_rst,
	output logic                cw_e_pff_rst,
	output logic                cw_m_pff_rst,
	output logic                cw_w_pff_rst,

	// Fetch stage.
	input  exc_pkg::npc_mode_t  cw_f_npc_jump_mode_orig,
	output exc_pkg::npc_mode_t  cw_f_npc_jump_mode,
	input  logic                cw_f_pc_enable_orig,
	output logic                cw_f_pc_enable,

	// Execute stage.
	input  logic                cw_e_pff_rst_orig,
	output logic                cw_e_md_restore,
	output logic                cw_e_md_stop,

	// Memory stage.
	input  logic                cw_m_dm_write_enable_orig,
	output logic                cw_m_dm_write_enable,
	input  logic                cw_m_cp0_write_enable_orig,
	output logic                cw_m_cp0_write_enable
);
	import exc_pkg::*;

	dptype_t d_dp;
	dptype_t e_dp;
	dptype_t m_dp;
	logic    rst;   // Active-high copy of the reset.
	logic    take;

	assign d_dp = dkind[KIND_W-1 -: DP_W];
	assign e_dp = ekind[KIND_W-1 -: DP_W];
	assign m_dp = mkind[KIND_W-1 -: DP_W];

	assign rst  = !rst_n;
	assign take = ctl.take;

	// The slot after an eret must not execute, so decode is cleared unless held by a stall.
	assign cw_d_pff_rst = rst || take || ((d_dp == DP_JUMP_C0) && !stall);

	// Execute keeps its own flush request for hazard bubbles.
	assign cw_e_pff_rst = rst || take || cw_e_pff_rst_orig;

	assign cw_m_pff_rst = rst || take; // The victim and younger work are squashed.
	assign cw_w_pff_rst = rst || take;

	// Send fetch to the vector.
	assign cw_f_npc_jump_mode = take ? NPC_ISR : cw_f_npc_jump_mode_orig;

	// The PC must load even if fetch was stalled.
	assign cw_f_pc_enable = take || cw_f_pc_enable_orig;

	// A mthi/mtlo that already reached HI/LO has to be undone.
	assign cw_e_md_restore = take && (m_dp == DP_STORE_M);

	// Any HI/LO update still in flight is frozen.
	assign cw_e_md_stop = take &&
		((e_dp == DP_CAL_M) || (m_dp == DP_CAL_M) || (e_dp == DP_STORE_M));

	// No architectural state changes from a trapped instruction.
	assign cw_m_dm_write_enable  = !take && cw_m_dm_write_enable_orig;
	assign cw_m_cp0_write_enable = !take && cw_m_cp0_write_enable_orig;

endmodule

/* design/exc_unit.sv */
`timescale 1ns/1ps

module exc_unit (
	input  logic                clk,
	input  logic                rst_n,

	// Stage kinds and hazard state.
	input  exc_pkg::kind_t      dkind,
	input  exc_pkg::kind_t      ekind,
	input  exc_pkg::kind_t      mkind,
	input  logic                stall,

	// Control-word overrides.
	output logic                cw_d_pff_rst,
	output logic                cw_e_pff_rst,
	output logic                cw_m_pff_rst,
	output logic                cw_w_pff_rst,
	input  exc_pkg::npc_mode_t  cw_f_npc_jump_mode_orig,
	output exc_pkg::npc_mode_t  cw_f_npc_jump_mode,
	input  logic                cw_f_pc_enable_orig,
	output logic                cw_f_pc_enable,
	input  logic                cw_e_pff_rst_orig,
	output logic                cw_e_md_restore,
	output logic                cw_e_md_stop,
	input  logic                cw_m_dm_write_enable_orig,
	output logic                cw_m_dm_write_enable,
	input  logic                cw_m_cp0_write_enable_orig,
	output logic                cw_m_cp0_write_enable,

	// Memory-stage trap sources.
	input  exc_pkg::exc_code_t  m_exc,
	input  exc_pkg::word_t      m_addr,
	input  exc_pkg::word_t      m_pc,
	input  logic                m_bd,
	input  exc_pkg::hw_int_t    hw_int,

	// mtc0 / mfc0 access.
	input  exc_pkg::cp0_addr_t  cp0_addr,
	input  exc_pkg::word_t      cp0_wdata,
	output exc_pkg::word_t      cp0_rdata,
	output exc_pkg::word_t      epc
);
	import exc_pkg::*;

	exc_if ctl (); // Trap decision and Status fields.

	exc_arbiter arb0 (
		.mkind  (mkind),
		.m_exc  (m_exc),
		.m_addr (m_addr),
		.m_pc   (m_pc),
		.m_bd   (m_bd),
		.hw_int (hw_int),
		.ctl    (ctl.arbiter)
	);

	// The CP0 write strobe is the handler's gated copy.
	cp0_regs cp0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.ctl    (ctl.cp0),
		.hw_int (hw_int),
		.we     (cw_m_cp0_write_enable),
		.addr   (cp0_addr),
		.wdata  (cp0_wdata),
		.rdata  (cp0_rdata),
		.epc    (epc)
	);

	exc_handler hdl0 (
		.rst_n                      (rst_n),
		.dkind                      (dkind),
		.ekind                      (ekind),
		.mkind                      (mkind),
		.stall                      (stall),
		.ctl                        (ctl.handler),
		.cw_d_pff_rst               (cw_d_pff_rst),
		.cw_e_pff_rst               (cw_e_pff_rst),
		.cw_m_pff_rst               (cw_m_pff_rst),
		.cw_w_pff_rst               (cw_w_pff_rst),
		.cw_f_npc_jump_mode_orig    (cw_f_npc_jump_mode_orig),
		.cw_f_npc_jump_mode         (cw_f_npc_jump_mode),
		.cw_f_pc_enable_orig        (cw_f_pc_enable_orig),
		.cw_f_pc_enable             (cw_f_pc_enable),
		.cw_e_pff_rst_orig          (cw_e_pff_rst_orig),
		.cw_e_md_restore            (cw_e_md_restore),
		.cw_e_md_stop               (cw_e_md_stop),
		.cw_m_dm_write_enable_orig  (cw_m_dm_write_enable_orig),
		.cw_m_dm_write_enable       (cw_m_dm_write_enable),
		.cw_m_cp0_write_enable_orig (cw_m_cp0_write_enable_orig),
		.cw_m_cp0_write_enable      (cw_m_cp0_write_enable)
	);

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/1ps

// Free-running clock and a reset that is held for a fixed number of rising edges.
module clk_gen #(
	parameter int RESET_CYCLES = 16 // Rising edges seen with rst_n low.
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

	// Release happens on an edge, so the DUT sees a whole cycle out of reset.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* bench/tb_exc_unit.sv */
`timescale 1ns/1ps

module tb_exc_unit;
	import exc_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_ROWS     = 26; // Data rows in the vector file.
	localparam int COLS         = 16; // Words per row.
	localparam int NUM_WORDS    = NUM_ROWS * COLS;
	localparam int CYCLE_LIMIT  = NUM_ROWS + RESET_CYCLES + 20;

	// Column positions inside one row of the vector file.
	localparam int COL_DKIND     = 0;
	localparam int COL_EKIND     = 1;
	localparam int COL_MKIND     = 2;
	localparam int COL_FLAGS_IN  = 3;  // stall, pc_en, e_rst, dm_we, cp0_we from bit 4 down.
	localparam int COL_NPC       = 4;
	localparam int COL_EXC       = 5;
	localparam int COL_ADDR      = 6;
	localparam int COL_PC        = 7;
	localparam int COL_BD        = 8;
	localparam int COL_HW_INT    = 9;
	localparam int COL_CP0_ADDR  = 10;
	localparam int COL_WDATA     = 11;
	localparam int COL_EXP_FLAGS = 12; // Nine expected output bits in the order check_row uses.
	localparam int COL_EXP_NPC   = 13;
	localparam int COL_EXP_RDATA = 14;
	localparam int COL_EXP_EPC   = 15;

	logic        clk;
	logic        rst_n;
	logic [31:0] vectors [0:NUM_WORDS-1];

	// DUT inputs.
	kind_t      dkind;
	kind_t      ekind;
	kind_t      mkind;
	logic       stall;
	npc_mode_t  cw_f_npc_jump_mode_orig;
	logic       cw_f_pc_enable_orig;
	logic       cw_e_pff_rst_orig;
	logic       cw_m_dm_write_enable_orig;
	logic       cw_m_cp0_write_enable_orig;
	exc_code_t  m_exc;
	word_t      m_addr;
	word_t      m_pc;
	logic       m_bd;
	hw_int_t    hw_int;
	cp0_addr_t  cp0_addr;
	word_t      cp0_wdata;

	// DUT outputs.
	logic       cw_d_pff_rst;
	logic       cw_e_pff_rst;
	logic       cw_m_pff_rst;
	logic       cw_w_pff_rst;
	npc_mode_t  cw_f_npc_jump_mode;
	logic       cw_f_pc_enable;
	logic       cw_e_md_restore;
	logic       cw_e_md_stop;
	logic       cw_m_dm_write_enable;
	logic       cw_m_cp0_write_enable;
	word_t      cp0_rdata;
	word_t      epc;

	int    errors = 0;
	int    checks = 0;
	int    cycles = 0;
	string where_now = "reset"; // Context shown on error lines.

	clk_gen #(.RESET_CYCLES(RESET_CYCLES)) clk0 (.clk(clk), .rst_n(rst_n));

	exc_unit dut0 (
		.clk                        (clk),
		.rst_n                      (rst_n),
		.dkind                      (dkind),
		.ekind                      (ekind),
		.mkind                      (mkind),
		.stall                      (stall),
		.cw_d_pff_rst               (cw_d_pff_rst),
		.cw_e_pff_rst               (cw_e_pff_rst),
		.cw_m_pff_rst               (cw_m_pff_rst),
		.cw_w_pff_rst               (cw_w_pff_rst),
		.cw_f_npc_jump_mode_orig    (cw_f_npc_jump_mode_orig),
		.cw_f_npc_jump_mode         (cw_f_npc_jump_mode),
		.cw_f_pc_enable_orig        (cw_f_pc_enable_orig),
		.cw_f_pc_enable             (cw_f_pc_enable),
		.cw_e_pff_rst_orig          (cw_e_pff_rst_orig),
		.cw_e_md_restore            (cw_e_md_restore),
		.cw_e_md_stop               (cw_e_md_stop),
		.cw_m_dm_write_enable_orig  (cw_m_dm_write_enable_orig),
		.cw_m_dm_write_enable       (cw_m_dm_write_enable),
		.cw_m_cp0_write_enable_orig (cw_m_cp0_write_enable_orig),
		.cw_m_cp0_write_enable      (cw_m_cp0_write_enable),
		.m_exc                      (m_exc),
		.m_addr                     (m_addr),
		.m_pc                       (m_pc),
		.m_bd                       (m_bd),
		.hw_int                     (hw_int),
		.cp0_addr                   (cp0_addr),
		.cp0_wdata                  (cp0_wdata),
		.cp0_rdata                  (cp0_rdata),
		.epc                        (epc)
	);

	// One comparison where X or Z on the DUT side counts as a mismatch.
	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s at %s: expected 0x%h, got 0x%h", name, where_now, exp, act);
		end
	endtask

	// Puts one row on the DUT inputs right at a rising edge.
	task automatic apply_row(input int row);
		int base;
		base = row * COLS;
		dkind                      <= vectors[base + COL_DKIND][KIND_W-1:0];
		ekind                      <= vectors[base + COL_EKIND][KIND_W-1:0];
		mkind                      <= vectors[base + COL_MKIND][KIND_W-1:0];
		stall                      <= vectors[base + COL_FLAGS_IN][4];
		cw_f_pc_enable_orig        <= vectors[base + COL_FLAGS_IN][3];
		cw_e_pff_rst_orig          <= vectors[base + COL_FLAGS_IN][2];
		cw_m_dm_write_enable_orig  <= vectors[base + COL_FLAGS_IN][1];
		cw_m_cp0_write_enable_orig <= vectors[base + COL_FLAGS_IN][0];
		cw_f_npc_jump_mode_orig    <= vectors[base + COL_NPC][NPC_W-1:0];
		m_exc                      <= vectors[base + COL_EXC][EXC_W-1:0];
		m_addr                     <= vectors[base + COL_ADDR];
		m_pc                       <= vectors[base + COL_PC];
		m_bd                       <= vectors[base + COL_BD][0];
		hw_int                     <= vectors[base + COL_HW_INT][HW_INT_W-1:0];
		cp0_addr                   <= vectors[base + COL_CP0_ADDR][CP0_ADDR_W-1:0];
		cp0_wdata                  <= vectors[base + COL_WDATA];
	endtask

	// Expected flag bits run d, e, m, w flush, pc enable, restore, stop, dm we, cp0 we.
	task automatic check_row(input int row);
		int         base;
		logic [8:0] flags;
		base  = row * COLS;
		flags = vectors[base + COL_EXP_FLAGS][8:0];
		compare("cw_d_pff_rst", flags[8], cw_d_pff_rst);
		compare("cw_e_pff_rst", flags[7], cw_e_pff_rst);
		compare("cw_m_pff_rst", flags[6], cw_m_pff_rst);
		compare("cw_w_pff_rst", flags[5], cw_w_pff_rst);
		compare("cw_f_pc_enable", flags[4], cw_f_pc_enable);
		compare("cw_e_md_restore", flags[3], cw_e_md_restore);
		compare("cw_e_md_stop", flags[2], cw_e_md_stop);
		compare("cw_m_dm_write_enable", flags[1], cw_m_dm_write_enable);
		compare("cw_m_cp0_write_enable", flags[0], cw_m_cp0_write_enable);
		compare("cw_f_npc_jump_mode", vectors[base + COL_EXP_NPC][NPC_W-1:0], cw_f_npc_jump_mode);
		compare("cp0_rdata", vectors[base + COL_EXP_RDATA], cp0_rdata);
		compare("epc", vectors[base + COL_EXP_EPC], epc);
	endtask

	// Hard stop in case the main sequence never reaches its end.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not end within %0d clock cycles.", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		// Idle values put bubbles everywhere and raise no requests.
		dkind                      = '0;
		ekind                      = '0;
		mkind                      = '0;
		stall                      = 1'b0;
		cw_f_npc_jump_mode_orig    = '0;
		cw_f_pc_enable_orig        = 1'b0;
		cw_e_pff_rst_orig          = 1'b0;
		cw_m_dm_write_enable_orig  = 1'b0;
		cw_m_cp0_write_enable_orig = 1'b0;
		m_exc                      = '0;
		m_addr                     = '0;
		m_pc                       = '0;
		m_bd                       = 1'b0;
		hw_int                     = '0;
		cp0_addr                   = '0;
		cp0_wdata                  = '0;

		$readmemh("bench/exc_tests.txt", vectors);
		if (vectors[NUM_WORDS-1] === 32'hx) begin
			errors++;
			$display("The vector file bench/exc_tests.txt is missing or has too few rows.");
		end

		// All four pipeline registers are held in reset by the reset alone.
		repeat (2) @(negedge clk);
		compare("cw_d_pff_rst", 32'd1, cw_d_pff_rst);
		compare("cw_e_pff_rst", 32'd1, cw_e_pff_rst);
		compare("cw_m_pff_rst", 32'd1, cw_m_pff_rst);
		compare("cw_w_pff_rst", 32'd1, cw_w_pff_rst);

		wait (rst_n === 1'b1);
		for (int row = 0; row < NUM_ROWS; row++) begin
			@(posedge clk);
			apply_row(row);
			@(negedge clk); // Combinational outputs have settled by mid-cycle.
			where_now = $sformatf("row %0d", row);
			check_row(row);
		end
		@(posedge clk);

		$display("Rows: %0d, checks: %0d, errors: %0d", NUM_ROWS, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* bench/exc_tests.txt */
// dkind ekind mkind flags_in npc_orig m_exc m_addr m_pc m_bd hw_int cp0_addr cp0_wdata
// then expected: flags(d e m w pc_en restore stop dm_we cp0_we) npc cp0_rdata epc
020 060 060 0a 2 00 00001000 00400000 0 00 0f 00000000 012 2 00000e1f 00000000
000 020 0a0 05 0 00 00000000 00400004 0 00 0f ffffffff 081 0 00000e1f 00000000
000 020 040 03 1 0c 00001004 00400100 0 00 0c 0000fc01 1fc 4 00000000 00000000
000 000 000 00 0 00 00000000 00000000 0 00 0d 00000000 000 0 00000030 00400100
000 000 000 00 0 00 00000000 00000000 0 00 0e 00000000 000 0 00400100 00400100
000 000 000 00 0 00 00000000 00000000 0 00 0c 00000000 000 0 00000002 00400100
000 040 060 00 0 0a 00002000 00400200 1 00 0e 00000000 1f4 4 00400100 00400100
000 000 000 00 0 00 00000000 00000000 0 00 0d 00000000 000 0 00000028 00400100
000 000 081 08 3 00 00000000 00400208 0 00 0c 00000000 010 3 00000002 00400100
000 000 000 00 0 00 00000000 00000000 0 00 0c 00000000 000 0 00000000 00400100
000 000 060 08 0 00 00001008 00400300 0 01 0d 00000000 010 0 00000428 00400100
000 000 0a0 01 0 00 00000000 00400304 0 00 0c 00000401 001 0 00000000 00400100
000 000 000 00 0 00 00000000 00000000 0 01 0c 00000000 000 0 00000401 00400100
081 000 061 02 0 00 00001001 00400400 0 01 0d 00000000 1f0 4 00000428 00400100
000 000 000 00 0 00 00000000 00000000 0 00 0d 00000000 000 0 00000000 00400400
000 000 000 00 0 00 00000000 00000000 0 00 0c 00000000 000 0 00000403 00400400
000 000 081 08 3 00 00000000 00400408 0 01 0e 00000000 010 3 00400400 00400400
081 000 000 10 0 00 00000000 00000000 0 00 0c 00000000 000 0 00000401 00400400
081 000 000 00 0 00 00000000 00000000 0 00 0c 00000000 100 0 00000401 00400400
000 020 060 00 0 00 00002002 00400500 1 00 0d 00000000 1f4 4 00000000 00400400
000 000 000 00 0 00 00000000 00000000 0 00 0d 00000000 000 0 80000010 004004fc
000 000 000 00 0 00 00000000 00000000 0 00 0e 00000000 000 0 004004fc 004004fc
000 000 041 02 0 00 00003003 00400600 0 00 0c 00000000 1f8 4 00000403 004004fc
000 000 000 00 0 00 00000000 00000000 0 00 0d 00000000 000 0 80000014 004004fc
000 000 042 02 0 00 00003003 00400604 0 00 0f 00000000 002 0 00000e1f 004004fc
000 000 041 02 0 00 00003002 00400608 0 00 0f 00000000 002 0 00000e1f 004004fc

/* all.f */
design/exc_pkg.sv
design/exc_if.sv
design/cp0_regs.sv
design/exc_arbiter.sv
design/exc_handler.sv
design/exc_unit.sv
bench/clk_gen.sv
bench/tb_exc_unit.sv

/* Bender.yml */
package:
  name: exc_unit

sources:
  - files:
      - design/exc_pkg.sv
      - design/exc_if.sv
      - design/cp0_regs.sv
      - design/exc_arbiter.sv
      - design/exc_handler.sv
      - design/exc_unit.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/tb_exc_unit.sv
